/* verilog.f */
qerv_pkg.sv
qerv_state.sv
qerv_decode.sv
qerv_immdec.sv
qerv_alu.sv
qerv_bufreg.sv
qerv_ctrl.sv
qerv_rf.sv
qerv_top.sv
qerv_sva.sv
tb_qerv.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   -f verilog.f \
   --top-module tb_qerv \
   -o tb_qerv_sim

./obj_dir/tb_qerv_sim

/* tb_qerv.sv */
module tb_qerv;

   localparam int              W          = 4;
   localparam qerv_pkg::word_t RESET_PC   = 32'h100;
   localparam int              N_INSTR    = 200;
   localparam logic [31:0]     SEED       = 32'd57;
   // One pass per instruction plus handshakes, doubled for margin
   localparam int              MAX_CYCLES = N_INSTR * (qerv_pkg::XLEN / W + 12) * 2;

   logic             clk;
   logic             i_rst_n;
   qerv_pkg::instr_t i_ibus_rdt = '0;
   logic             i_ibus_ack = 1'b0;
   logic             i_dbus_ack = 1'b0;
   qerv_pkg::word_t  o_ibus_adr;
   logic             o_ibus_cyc;
   qerv_pkg::word_t  o_dbus_adr;
   qerv_pkg::word_t  o_dbus_dat;
   logic             o_dbus_cyc;

   qerv_pkg::instr_t prog [N_INSTR];
   qerv_pkg::word_t  model_regs [32];
   logic [31:0]      ibus_rand;
   logic [31:0]      dbus_rand;
   logic [1:0]       ibus_wait;
   logic [1:0]       dbus_wait;
   int               cycles = 0;

   qerv_top #(.W(W), .RESET_PC(RESET_PC)) i_qerv_top (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_cyc (o_dbus_cyc)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // funct3 for ADD, SLT, SLTU, XOR, OR, AND in that order
   function automatic logic [2:0] op_f3(input logic [3:0] k);
      case (k)
         4'd1:    return 3'b010;
         4'd2:    return 3'b011;
         4'd3:    return 3'b100;
         4'd4:    return 3'b110;
         4'd5:    return 3'b111;
         default: return 3'b000;
      endcase
   endfunction

   function automatic qerv_pkg::instr_t enc_r(input logic sub, input qerv_pkg::reg_addr_t rs2,
         input qerv_pkg::reg_addr_t rs1, input logic [2:0] f3, input qerv_pkg::reg_addr_t rd);
      return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic qerv_pkg::instr_t enc_i(input logic [11:0] imm,
         input qerv_pkg::reg_addr_t rs1, input logic [2:0] f3, input qerv_pkg::reg_addr_t rd);
      return {imm, rs1, f3, rd, 7'b0010011};
   endfunction

   function automatic qerv_pkg::instr_t enc_s(input logic [11:0] imm,
         input qerv_pkg::reg_addr_t rs2, input qerv_pkg::reg_addr_t rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic qerv_pkg::instr_t enc_u(input logic [19:0] imm,
         input qerv_pkg::reg_addr_t rd);
      return {imm, rd, 7'b0110111};
   endfunction

   task automatic build_program();
      logic [31:0]         r;
      logic [3:0]          kind;
      logic [11:0]         imm;
      qerv_pkg::reg_addr_t rd;
      qerv_pkg::reg_addr_t rs1;
      qerv_pkg::reg_addr_t rs2;
      r = SEED;
      for (int n = 1; n < 32; n++) begin
         r = lcg_next(r);
         prog[2 * n - 2] = enc_u(r[31:12], 5'(n));
         r = lcg_next(r);
         prog[2 * n - 1] = enc_i(r[31:20], 5'(n), 3'b000, 5'(n));
      end
      for (int i = 62; i < N_INSTR; i++) begin
         r = lcg_next(r);
         rd  = r[31:27];
         rs1 = r[26:22];
         rs2 = r[21:17];
         r = lcg_next(r);
         kind = r[31:28];
         imm  = r[27:16];
         // Forced x0 targets and x0 stores
         if (i % 23 == 0) begin
            rd = '0;
         end
         if (i % 15 == 4) begin
            rs2 = '0;
         end
         if (i % 5 == 4) begin
            prog[i] = enc_s(imm, rs2, rs1);
         end else if (kind < 4'd6) begin
            prog[i] = enc_i(imm, rs1, op_f3(kind), rd);
         end else if (kind < 4'd12) begin
            prog[i] = enc_r(1'b0, rs2, rs1, op_f3(kind - 4'd6), rd);
         end else if (kind == 4'd12) begin
            prog[i] = enc_r(1'b1, rs2, rs1, 3'b000, rd);
         end else if (kind == 4'd13) begin
            prog[i] = enc_u(r[31:12], rd);
         end else begin
            // Compare of a register with itself
            prog[i] = enc_r(1'b0, rs1, rs1, op_f3(kind - 4'd13), rd);
         end
      end
   endtask

   function automatic qerv_pkg::instr_t fetch_word(input qerv_pkg::word_t adr);
      int idx;
      idx = int'((adr - RESET_PC) >> 2);
      if (idx >= 0 && idx < N_INSTR) begin
         return prog[idx];
      end
      return 32'h0000_0013;
   endfunction

   // Runs one instruction on the model register file by RV32I rules and returns the next PC
   function automatic qerv_pkg::word_t ref_exec(input qerv_pkg::instr_t ins,
         input qerv_pkg::word_t pc, output logic is_sw, output qerv_pkg::word_t adr,
         output qerv_pkg::word_t dat);
      qerv_pkg::word_t a;
      qerv_pkg::word_t b;
      qerv_pkg::word_t res;
      logic            wr;
      a     = model_regs[ins[19:15]];
      b     = (ins[6:0] == 7'b0110011) ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
      res   = '0;
      wr    = 1'b0;
      is_sw = 1'b0;
      adr   = '0;
      dat   = '0;
      case (ins[6:0])
         7'b0110111: begin
            res = {ins[31:12], 12'b0};
            wr  = 1'b1;
         end
         7'b0010011, 7'b0110011: begin
            wr = 1'b1;
            case (ins[14:12])
               3'b000:  res = (ins[6:0] == 7'b0110011 && ins[30]) ? a - b : a + b;
               3'b010:  res = {31'b0, $signed(a) < $signed(b)};
               3'b011:  res = {31'b0, a < b};
               3'b100:  res = a ^ b;
               3'b110:  res = a | b;
               3'b111:  res = a & b;
               default: wr = 1'b0;
            endcase
         end
         7'b0100011: begin
            is_sw = 1'b1;
            adr   = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            dat   = model_regs[ins[24:20]];
         end
         default: ;
      endcase
      if (wr && ins[11:7] != 5'd0) begin
         model_regs[ins[11:7]] = res;
      end
      return pc + 32'd4;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("sim failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic compare_word(input string what, input qerv_pkg::word_t got,
         input qerv_pkg::word_t exp);
      if (got !== exp) begin
         abort_run($sformatf("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic compare_pc(input qerv_pkg::word_t got, input qerv_pkg::word_t exp);
      if (got !== exp) begin
         abort_run($sformatf("Fail at time %0t: fetch address is %h, expected %h",
                             $time, got, exp));
      end
   endtask

   initial begin
      clk = 1'b0;
      forever begin
         #20 clk = ~clk;
      end
   end

   initial begin
      i_rst_n = 1'b0;
      build_program();
      repeat (10) @(posedge clk);
      i_rst_n <= 1'b1;
   end

   always @(posedge clk) begin
      if (!i_rst_n) begin
         i_ibus_ack <= 1'b0;
         ibus_rand  <= SEED + 32'd1;
         ibus_wait  <= 2'd0;
      end else if (o_ibus_cyc && !i_ibus_ack) begin
         if (ibus_wait == 2'd0) begin
            i_ibus_ack <= 1'b1;
            i_ibus_rdt <= fetch_word(o_ibus_adr);
            ibus_wait  <= ibus_rand[31:30];
            ibus_rand  <= lcg_next(ibus_rand);
         end else begin
            ibus_wait <= ibus_wait - 2'd1;
         end
      end else begin
         i_ibus_ack <= 1'b0;
      end
   end

   always @(posedge clk) begin
      if (!i_rst_n) begin
         i_dbus_ack <= 1'b0;
         dbus_rand  <= SEED + 32'd2;
         dbus_wait  <= 2'd1;
      end else if (o_dbus_cyc && !i_dbus_ack) begin
         if (dbus_wait == 2'd0) begin
            i_dbus_ack <= 1'b1;
            dbus_wait  <= dbus_rand[31:30];
            dbus_rand  <= lcg_next(dbus_rand);
         end else begin
            dbus_wait <= dbus_wait - 2'd1;
         end
      end else begin
         i_dbus_ack <= 1'b0;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles with the program unfinished", cycles);
         $display("sim failed");
         $fatal(1, "timeout");
      end
   end

   initial begin : check_run
      qerv_pkg::word_t exp_pc;
      qerv_pkg::word_t exp_adr;
      qerv_pkg::word_t exp_dat;
      logic            exp_sw;
      logic            store_due;
      logic            cyc_d;
      logic            done;
      int              fetched;
      for (int r = 0; r < 32; r++) begin
         model_regs[r] = '0;
      end
      exp_pc    = RESET_PC;
      exp_adr   = '0;
      exp_dat   = '0;
      exp_sw    = 1'b0;
      store_due = 1'b0;
      cyc_d     = 1'b0;
      done      = 1'b0;
      fetched   = 0;
      wait (i_rst_n === 1'b1);
      while (!done) begin
         @(posedge clk);
         if (o_dbus_cyc && i_dbus_ack) begin
            if (!store_due) begin
               abort_run("Data bus write seen with no store outstanding");
            end
            compare_word("store address", o_dbus_adr, exp_adr);
            compare_word("store data", o_dbus_dat, exp_dat);
            store_due = 1'b0;
         end
         // Rising fetch cyc closes the previous instruction
         if (o_ibus_cyc && !cyc_d) begin
            if (store_due) begin
               abort_run("Store instruction retired without a data bus write");
            end
            compare_pc(o_ibus_adr, exp_pc);
            if (fetched == N_INSTR) begin
               done = 1'b1;
            end else begin
               exp_pc    = ref_exec(prog[fetched], exp_pc, exp_sw, exp_adr, exp_dat);
               store_due = exp_sw;
               fetched++;
            end
         end
         cyc_d = o_ibus_cyc;
      end
      $display("sim passed");
      $finish;
   end

endmodule

/* qerv_sva.sv */
module qerv_sva (
   input logic            clk,
   input logic            i_rst_n,
   input logic            i_ibus_cyc,
   input logic            i_ibus_ack,
   input qerv_pkg::word_t i_ibus_adr,
   input logic            i_dbus_cyc,
   input logic            i_dbus_ack,
   input qerv_pkg::word_t i_dbus_adr,
   input qerv_pkg::word_t i_dbus_dat
);

   // A cyc ends only in the cycle after its ack
   ibus_drop_on_ack: assert property (@(posedge clk) disable iff (!i_rst_n)
      $fell(i_ibus_cyc) |-> $past(i_ibus_ack))
      else $error("instruction bus cyc dropped without an ack");

   dbus_drop_on_ack: assert property (@(posedge clk) disable iff (!i_rst_n)
      $fell(i_dbus_cyc) |-> $past(i_dbus_ack))
      else $error("data bus cyc dropped without an ack");

   one_bus_active: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_ibus_cyc && i_dbus_cyc))
      else $error("instruction and data bus cycles overlap");

   ibus_adr_held: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_ibus_cyc && $past(i_ibus_cyc)) |-> $stable(i_ibus_adr))
      else $error("fetch address changed during a bus cycle");

   dbus_req_held: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_dbus_cyc && $past(i_dbus_cyc)) |-> ($stable(i_dbus_adr) && $stable(i_dbus_dat)))
      else $error("store address or data changed during a bus cycle");

endmodule

bind qerv_top qerv_sva sva (
   .clk        (clk),
   .i_rst_n    (i_rst_n),
   .i_ibus_cyc (o_ibus_cyc),
   .i_ibus_ack (i_ibus_ack),
   .i_ibus_adr (o_ibus_adr),
   .i_dbus_cyc (o_dbus_cyc),
   .i_dbus_ack (i_dbus_ack),
   .i_dbus_adr (o_dbus_adr),
   .i_dbus_dat (o_dbus_dat)
);

/* qerv_top.sv */
module qerv_top #(
   parameter int              W        = 1,
   parameter qerv_pkg::word_t RESET_PC = '0
) (
   input  logic             clk,
   input  logic             i_rst_n,
   input  qerv_pkg::instr_t i_ibus_rdt,
   input  logic             i_ibus_ack,
   input  logic             i_dbus_ack,
   output qerv_pkg::word_t  o_ibus_adr,
   output logic             o_ibus_cyc,
   output qerv_pkg::word_t  o_dbus_adr,
   output qerv_pkg::word_t  o_dbus_dat,
   output logic             o_dbus_cyc
);

   logic                decode_en;
   logic                cnt_en;
   logic                cnt0;
   logic                cnt_done;
   logic                commit;
   logic                store;
   logic                rd_en;
   logic                op_b_imm;
   logic                sub;
   qerv_pkg::alu_bool_t bool_op;
   logic                rd_sel_add;
   logic                rd_sel_bool;
   logic                rd_sel_cmp;
   logic                rd_sel_imm;
   logic                cmp_signed;
   logic                imm_type_s;
   logic                imm_type_u;
   qerv_pkg::reg_addr_t rs1_addr;
   qerv_pkg::reg_addr_t rs2_addr;
   qerv_pkg::reg_addr_t rd_addr;
   logic [W-1:0]        rs1;
   logic [W-1:0]        rs2;
   logic [W-1:0]        imm;
   logic [W-1:0]        alu_rd;
   logic                alu_cmp;

   qerv_state #(.W(W)) state (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .i_store    (store),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_cyc (o_dbus_cyc),
      .o_decode   (decode_en),
      .o_cnt_en   (cnt_en),
      .o_cnt0     (cnt0),
      .o_cnt_done (cnt_done),
      .o_commit   (commit)
   );

   qerv_decode decode (
      .clk           (clk),
      .i_ibus_ack    (i_ibus_ack),
      .i_ibus_rdt    (i_ibus_rdt),
      .o_store       (store),
      .o_rd_en       (rd_en),
      .o_op_b_imm    (op_b_imm),
      .o_sub         (sub),
      .o_bool_op     (bool_op),
      .o_rd_sel_add  (rd_sel_add),
      .o_rd_sel_bool (rd_sel_bool),
      .o_rd_sel_cmp  (rd_sel_cmp),
      .o_rd_sel_imm  (rd_sel_imm),
      .o_cmp_signed  (cmp_signed),
      .o_imm_type_s  (imm_type_s),
      .o_imm_type_u  (imm_type_u)
   );

   qerv_immdec #(.W(W)) immdec (
      .clk          (clk),
      .i_ibus_ack   (i_ibus_ack),
      .i_ibus_rdt   (i_ibus_rdt),
      .i_cnt_en     (cnt_en),
      .i_imm_type_s (imm_type_s),
      .i_imm_type_u (imm_type_u),
      .o_rs1_addr   (rs1_addr),
      .o_rs2_addr   (rs2_addr),
      .o_rd_addr    (rd_addr),
      .o_imm        (imm)
   );

   // Operand B is picked between rs2 and imm inside the ALU
   qerv_alu #(.W(W)) alu (
      .clk           (clk),
      .i_cnt_en      (cnt_en),
      .i_cnt0        (cnt0),
      .i_cnt_done    (cnt_done),
      .i_rs1         (rs1),
      .i_rs2         (rs2),
      .i_imm         (imm),
      .i_op_b_imm    (op_b_imm),
      .i_sub         (sub),
      .i_bool_op     (bool_op),
      .i_cmp_signed  (cmp_signed),
      .i_rd_sel_add  (rd_sel_add),
      .i_rd_sel_bool (rd_sel_bool),
      .i_rd_sel_cmp  (rd_sel_cmp),
      .o_rd          (alu_rd),
      .o_cmp         (alu_cmp)
   );

   qerv_bufreg #(.W(W)) bufreg (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_cnt0     (cnt0),
      .i_rs1      (rs1),
      .i_imm      (imm),
      .i_rs2      (rs2),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat)
   );

   qerv_ctrl #(.W(W), .RESET_PC(RESET_PC)) ctrl (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_commit   (commit),
      .o_ibus_adr (o_ibus_adr)
   );

   qerv_rf #(.W(W)) rf (
      .clk          (clk),
      .i_decode     (decode_en),
      .i_cnt_en     (cnt_en),
      .i_commit     (commit),
      .i_rd_en      (rd_en),
      .i_rs1_addr   (rs1_addr),
      .i_rs2_addr   (rs2_addr),
      .i_rd_addr    (rd_addr),
      .i_rd_alu     (alu_rd),
      .i_rd_imm_sel (rd_sel_imm),
      .i_imm        (imm),
      .i_rd_cmp_sel (rd_sel_cmp),
      .i_cmp        (alu_cmp),
      .o_rs1        (rs1),
      .o_rs2        (rs2)
   );

endmodule

/* qerv_rf.sv */
module qerv_rf #(
   parameter int W = 1
) (
   input  logic                clk,
   input  logic                i_decode,
   input  logic                i_cnt_en,
   input  logic                i_commit,
   input  logic                i_rd_en,
   input  qerv_pkg::reg_addr_t i_rs1_addr,
   input  qerv_pkg::reg_addr_t i_rs2_addr,
   input  qerv_pkg::reg_addr_t i_rd_addr,
   input  logic [W-1:0]        i_rd_alu,
   input  logic                i_rd_imm_sel,
   input  logic [W-1:0]        i_imm,
   input  logic                i_rd_cmp_sel,
   input  logic                i_cmp,
   output logic [W-1:0]        o_rs1,
   output logic [W-1:0]        o_rs2
);

   qerv_pkg::word_t regs [1:31];
   qerv_pkg::word_t rs1_sr;
   qerv_pkg::word_t rs2_sr;
   qerv_pkg::word_t rd_sr;
   qerv_pkg::word_t rd_word;
   logic [W-1:0]    rd_slice;

   assign rd_slice = i_rd_imm_sel ? i_imm : i_rd_alu;
   // Compare result is a single bit known only after the last slice
   assign rd_word  = i_rd_cmp_sel ? {{(qerv_pkg::XLEN-1){1'b0}}, i_cmp} : rd_sr;

   always_ff @(posedge clk) begin
      if (i_decode) begin
         rs1_sr <= (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
         rs2_sr <= (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];
      end else if (i_cnt_en) begin
         rs1_sr <= {{W{1'b0}}, rs1_sr[qerv_pkg::XLEN-1:W]};
         rs2_sr <= {{W{1'b0}}, rs2_sr[qerv_pkg::XLEN-1:W]};
      end
      if (i_cnt_en) begin
         rd_sr <= {rd_slice, rd_sr[qerv_pkg::XLEN-1:W]};
      end
   end

   // x0 has no storage
   always_ff @(posedge clk) begin
      if (i_commit && i_rd_en && (i_rd_addr != '0)) begin
         regs[i_rd_addr] <= rd_word;
      end
   end

   assign o_rs1 = rs1_sr[W-1:0];
   assign o_rs2 = rs2_sr[W-1:0];

endmodule

/* qerv_ctrl.sv */
module qerv_ctrl #(
   parameter int              W        = 1,
   parameter qerv_pkg::word_t RESET_PC = '0
) (
   input  logic            clk,
   input  logic            i_rst_n,
   input  logic            i_commit,
   output qerv_pkg::word_t o_ibus_adr
);

   // Slice width has to split a word evenly for the bit counter
   if (!(W == 1 || W == 2 || W == 4)) begin : g_w_check
      $error("qerv_ctrl: W must be 1, 2 or 4");
   end

   // No jumps or branches, so every commit moves to the next word
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_ibus_adr <= RESET_PC;
      end else if (i_commit) begin
         o_ibus_adr <= o_ibus_adr + 32'd4;
      end
   end

endmodule

/* qerv_bufreg.sv */
module qerv_bufreg #(
   parameter int W = 1
) (
   input  logic            clk,
   input  logic            i_cnt_en,
   input  logic            i_cnt0,
   input  logic [W-1:0]    i_rs1,
   input  logic [W-1:0]    i_imm,
   input  logic [W-1:0]    i_rs2,
   output qerv_pkg::word_t o_dbus_adr,
   output qerv_pkg::word_t o_dbus_dat
);

   logic [W-1:0] sum;
   logic         carry_in;
   logic         carry_out;
   logic         carry_r;

   assign carry_in = ~i_cnt0 & carry_r;
   assign {carry_out, sum} = {1'b0, i_rs1} + {1'b0, i_imm} + {{W{1'b0}}, carry_in};

   // Both words fill LSB first and then hold until the next EXEC
   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_r    <= carry_out;
         o_dbus_adr <= {sum, o_dbus_adr[qerv_pkg::XLEN-1:W]};
         o_dbus_dat <= {i_rs2, o_dbus_dat[qerv_pkg::XLEN-1:W]};
      end
   end

endmodule

/* qerv_alu.sv */
module qerv_alu #(
   parameter int W = 1
) (
   input  logic                clk,
   input  logic                i_cnt_en,
   input  logic                i_cnt0,
   input  logic                i_cnt_done,
   input  logic [W-1:0]        i_rs1,
   input  logic [W-1:0]        i_rs2,
   input  logic [W-1:0]        i_imm,
   input  logic                i_op_b_imm,
   input  logic                i_sub,
   input  qerv_pkg::alu_bool_t i_bool_op,
   input  logic                i_cmp_signed,
   input  logic                i_rd_sel_add,
   input  logic                i_rd_sel_bool,
   input  logic                i_rd_sel_cmp,
   output logic [W-1:0]        o_rd,
   output logic                o_cmp
);

   logic [W-1:0] op_b;
   logic [W-1:0] b_add;
   logic [W-1:0] sum;
   logic [W-1:0] bool_res;
   logic         carry_in;
   logic         carry_out;
   logic         carry_r;
   logic         lt;
   logic         cmp_r;

   assign op_b     = i_op_b_imm ? i_imm : i_rs2;
   assign b_add    = i_sub ? ~op_b : op_b;
   // Subtract seeds the +1 of the two's complement on the first slice
   assign carry_in = i_cnt0 ? i_sub : carry_r;
   assign {carry_out, sum} = {1'b0, i_rs1} + {1'b0, b_add} + {{W{1'b0}}, carry_in};

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_r <= carry_out;
      end
      if (i_cnt_done) begin
         cmp_r <= i_rd_sel_cmp & lt;
      end
   end

   // Only meaningful on the top slice
   always_comb begin
      if (!i_cmp_signed) begin
         lt = ~carry_out;
      end else if (i_rs1[W-1] != op_b[W-1]) begin
         lt = i_rs1[W-1];
      end else begin
         lt = sum[W-1];
      end
   end

   always_comb begin
      case (i_bool_op)
         qerv_pkg::BOOL_OR:  bool_res = i_rs1 | op_b;
         qerv_pkg::BOOL_AND: bool_res = i_rs1 & op_b;
         default:            bool_res = i_rs1 ^ op_b;
      endcase
   end

   assign o_rd  = ({W{i_rd_sel_add}} & sum) | ({W{i_rd_sel_bool}} & bool_res);
   assign o_cmp = cmp_r;

endmodule

/* qerv_immdec.sv */
module qerv_immdec #(
   parameter int W = 1
) (
   input  logic                clk,
   input  logic                i_ibus_ack,
   input  qerv_pkg::instr_t    i_ibus_rdt,
   input  logic                i_cnt_en,
   input  logic                i_imm_type_s,
   input  logic                i_imm_type_u,
   output qerv_pkg::reg_addr_t o_rs1_addr,
   output qerv_pkg::reg_addr_t o_rs2_addr,
   output qerv_pkg::reg_addr_t o_rd_addr,
   output logic [W-1:0]        o_imm
);

   logic [31:7]     ir;
   qerv_pkg::word_t imm_word;
   qerv_pkg::word_t imm_sr;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         ir <= i_ibus_rdt[31:7];
      end
   end

   assign o_rd_addr  = ir[11:7];
   assign o_rs1_addr = ir[19:15];
   assign o_rs2_addr = ir[24:20];

   always_comb begin
      if (i_imm_type_u) begin
         imm_word = {ir[31:12], 12'b0};
      end else if (i_imm_type_s) begin
         imm_word = {{20{ir[31]}}, ir[31:25], ir[11:7]};
      end else begin
         imm_word = {{20{ir[31]}}, ir[31:20]};
      end
   end

   // Reloads while idle so the word is ready when EXEC starts
   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         imm_sr <= {{W{1'b0}}, imm_sr[qerv_pkg::XLEN-1:W]};
      end else begin
         imm_sr <= imm_word;
      end
   end

   assign o_imm = imm_sr[W-1:0];

endmodule

/* qerv_decode.sv */
module qerv_decode (
   input  logic                clk,
   input  logic                i_ibus_ack,
   input  qerv_pkg::instr_t    i_ibus_rdt,
   output logic                o_store,
   output logic                o_rd_en,
   output logic                o_op_b_imm,
   output logic                o_sub,
   output qerv_pkg::alu_bool_t o_bool_op,
   output logic                o_rd_sel_add,
   output logic                o_rd_sel_bool,
   output logic                o_rd_sel_cmp,
   output logic                o_rd_sel_imm,
   output logic                o_cmp_signed,
   output logic                o_imm_type_s,
   output logic                o_imm_type_u
);

   logic [6:0] opcode_r;
   logic [2:0] funct3_r;
   logic       funct7_5_r;

   logic is_op;
   logic is_op_imm;
   logic is_lui;
   logic is_store;
   logic alu_op;
   logic f3_add;
   logic f3_cmp;
   logic f3_bool;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         opcode_r   <= i_ibus_rdt[6:0];
         funct3_r   <= i_ibus_rdt[14:12];
         funct7_5_r <= i_ibus_rdt[30];
      end
   end

   assign is_op     = (opcode_r == qerv_pkg::OPC_OP);
   assign is_op_imm = (opcode_r == qerv_pkg::OPC_OP_IMM);
   assign is_lui    = (opcode_r == qerv_pkg::OPC_LUI);
   assign is_store  = (opcode_r == qerv_pkg::OPC_STORE);
   assign alu_op    = is_op | is_op_imm;

   assign f3_add  = (funct3_r == qerv_pkg::F3_ADD);
   assign f3_cmp  = (funct3_r == qerv_pkg::F3_SLT) || (funct3_r == qerv_pkg::F3_SLTU);
   assign f3_bool = (funct3_r == qerv_pkg::F3_XOR) || (funct3_r == qerv_pkg::F3_OR) ||
                    (funct3_r == qerv_pkg::F3_AND);

   // Shift encodings fall through with no rd source and no write
   assign o_rd_sel_add  = alu_op & f3_add;
   assign o_rd_sel_bool = alu_op & f3_bool;
   assign o_rd_sel_cmp  = alu_op & f3_cmp;
   assign o_rd_sel_imm  = is_lui;
   assign o_rd_en       = o_rd_sel_add | o_rd_sel_bool | o_rd_sel_cmp | o_rd_sel_imm;
   assign o_store       = is_store;

   // Bit 30 belongs to the immediate for ADDI, so only OP can subtract
   assign o_sub        = (is_op & f3_add & funct7_5_r) | f3_cmp;
   assign o_op_b_imm   = is_op_imm;
   assign o_bool_op    = qerv_pkg::alu_bool_t'(funct3_r[1:0]);
   assign o_cmp_signed = (funct3_r == qerv_pkg::F3_SLT);

   assign o_imm_type_s = is_store;
   assign o_imm_type_u = is_lui;

endmodule

/* qerv_state.sv */
module qerv_state #(
   parameter int W = 1
) (
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_ibus_ack,
   input  logic i_dbus_ack,
   input  logic i_store,
   output logic o_ibus_cyc,
   output logic o_dbus_cyc,
   output logic o_decode,
   output logic o_cnt_en,
   output logic o_cnt0,
   output logic o_cnt_done,
   output logic o_commit
);

   localparam int CNT_W = $clog2(qerv_pkg::XLEN / W);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(qerv_pkg::XLEN / W - 1);

   qerv_pkg::core_state_t state;
   qerv_pkg::core_state_t state_nxt;
   logic [CNT_W-1:0]      cnt;

   always_comb begin
      state_nxt = state;
      case (state)
         qerv_pkg::IDLE:   state_nxt = qerv_pkg::FETCH;
         qerv_pkg::FETCH:  state_nxt = i_ibus_ack ? qerv_pkg::DECODE : qerv_pkg::FETCH;
         qerv_pkg::DECODE: state_nxt = qerv_pkg::EXEC;
         qerv_pkg::EXEC:   state_nxt = (cnt == CNT_LAST) ? qerv_pkg::COMMIT : qerv_pkg::EXEC;
         // Stores go out only after rd and PC are settled
         qerv_pkg::COMMIT: state_nxt = i_store ? qerv_pkg::STORE : qerv_pkg::FETCH;
         qerv_pkg::STORE:  state_nxt = i_dbus_ack ? qerv_pkg::FETCH : qerv_pkg::STORE;
         default:          state_nxt = qerv_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state <= qerv_pkg::IDLE;
         cnt   <= '0;
      end else begin
         state <= state_nxt;
         if (o_cnt_en) begin
            cnt <= cnt + CNT_W'(1);
         end
      end
   end

   assign o_ibus_cyc = (state == qerv_pkg::FETCH);
   assign o_dbus_cyc = (state == qerv_pkg::STORE);
   assign o_decode   = (state == qerv_pkg::DECODE);
   assign o_cnt_en   = (state == qerv_pkg::EXEC);
   assign o_commit   = (state == qerv_pkg::COMMIT);
   assign o_cnt0     = o_cnt_en & (cnt == '0);
   assign o_cnt_done = o_cnt_en & (cnt == CNT_LAST);

endmodule

/* qerv_pkg.sv */
package qerv_pkg;

   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [4:0]      reg_addr_t;
   typedef logic [XLEN-1:0] instr_t;

   // Major opcodes the core executes
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_STORE  = 7'b0100011
   } opcode_t;

   // Taken straight from funct3[1:0] of the logic ops
   typedef enum logic [1:0] {
      BOOL_XOR = 2'b00,
      BOOL_OR  = 2'b10,
      BOOL_AND = 2'b11
   } alu_bool_t;

   typedef enum logic [2:0] {
      IDLE,
      FETCH,
      DECODE,
      EXEC,
      COMMIT,
      STORE
   } core_state_t;

   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

endpackage
